//--- Makefile
VERILATOR ?= verilator
TOP       ?= csu_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	  echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/csr_file.sv
module csr_file (
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  input  logic [csu_pkg::CSR_ADDR_W-1:0] i_rd_addr,
  output logic [csu_pkg::XLEN-1:0]       o_rd_data,
  input  logic                           i_wr_valid,
  input  logic [csu_pkg::CSR_ADDR_W-1:0] i_wr_addr,
  input  logic [csu_pkg::XLEN-1:0]       i_wr_data
);

  import csu_pkg::*;

  logic [XLEN-1:0] r_mstatus;
  logic [XLEN-1:0] r_mtvec;
  logic [XLEN-1:0] r_mscratch;
  logic [XLEN-1:0] r_mepc;
  logic            w_bypass;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_mstatus  <= '0;
      r_mtvec    <= '0;
      r_mscratch <= '0;
      r_mepc     <= '0;
    end else if (i_wr_valid) begin
      case (i_wr_addr)
        CSR_MSTATUS:  r_mstatus  <= i_wr_data;
        CSR_MTVEC:    r_mtvec    <= i_wr_data;
        CSR_MSCRATCH: r_mscratch <= i_wr_data;
        CSR_MEPC:     r_mepc     <= i_wr_data;
        default: ;  // Unimplemented CSRs drop the write
      endcase
    end
  end

  assign w_bypass = i_wr_valid && (i_wr_addr == i_rd_addr);

  // Bypass only applies inside a known address so unknown CSRs keep reading zero
  always_comb begin
    case (i_rd_addr)
      CSR_MSTATUS:  o_rd_data = w_bypass ? i_wr_data : r_mstatus;
      CSR_MTVEC:    o_rd_data = w_bypass ? i_wr_data : r_mtvec;
      CSR_MSCRATCH: o_rd_data = w_bypass ? i_wr_data : r_mscratch;
      CSR_MEPC:     o_rd_data = w_bypass ? i_wr_data : r_mepc;
      default:      o_rd_data = '0;
    endcase
  end

  // Write data comes from rs1 forwarding in the pipe; an undriven source
  // register would otherwise poison architectural state
  a_wr_data_known : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_wr_valid |-> !$isunknown(i_wr_data)
  ) else $error("csr_file: write to 0x%03h with unknown data", i_wr_addr);

endmodule

//--- hdl/csu_decoder.sv
module csu_decoder (
  input  logic [31:0]      i_inst,
  output csu_pkg::csu_op_e o_op
);

  import csu_pkg::*;

  logic [6:0] w_opcode;
  logic [2:0] w_funct3;

  assign w_opcode = i_inst[6:0];
  assign w_funct3 = i_inst[14:12];

  always_comb begin
    o_op = OP_NONE;
    if (i_inst == INST_MRET) begin
      o_op = OP_MRET;
    end else if (w_opcode == OPC_SYSTEM) begin
      case (w_funct3)
        F3_CSRRW: o_op = OP_RW;
        F3_CSRRS: o_op = OP_RS;
        F3_CSRRC: o_op = OP_RC;
        default:  o_op = OP_NONE;  // Immediate forms and ECALL/EBREAK are not handled here
      endcase
    end
  end

endmodule

//--- hdl/csu_pipe.sv
module csu_pipe (
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  input  csu_pkg::issue_t                i_issue,
  output logic [31:0]                    o_dec_inst,
  input  csu_pkg::csu_op_e               i_dec_op,
  output logic [csu_pkg::RNID_W-1:0]     o_rs1_rnid,
  input  logic [csu_pkg::XLEN-1:0]       i_rs1_data,
  input  csu_pkg::phy_wr_t               i_ext_wr,
  output logic [csu_pkg::CSR_ADDR_W-1:0] o_csr_rd_addr,
  input  logic [csu_pkg::XLEN-1:0]       i_csr_rd_data,
  output logic                           o_csr_wr_valid,
  output logic [csu_pkg::CSR_ADDR_W-1:0] o_csr_wr_addr,
  output logic [csu_pkg::XLEN-1:0]       o_csr_wr_data,
  output csu_pkg::phy_wr_t               o_phy_wr,
  output csu_pkg::done_t                 o_done
);

  import csu_pkg::*;

  typedef struct packed {
    issue_t  issue;
    csu_op_e op;
  } stage_t;

  logic            r_ex1_valid;
  logic            r_ex2_valid;
  logic            r_ex3_valid;
  stage_t          r_ex1;
  stage_t          r_ex2;
  stage_t          r_ex3;
  logic [XLEN-1:0] r_ex2_rs1_data;
  logic            w_fwd_ext;
  logic            w_fwd_own;
  logic [XLEN-1:0] w_ex2_rs1;
  logic [XLEN-1:0] w_ex2_new;
  logic [XLEN-1:0] r_ex3_old;
  logic [XLEN-1:0] r_ex3_new;
  logic            w_ex3_mret;

  assign o_dec_inst = i_issue.inst;  // Decode happens in ex0, same cycle as issue

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
      r_ex2_valid <= 1'b0;
      r_ex3_valid <= 1'b0;
    end else begin
      r_ex1_valid <= i_issue.valid;
      r_ex2_valid <= r_ex1_valid;
      r_ex3_valid <= r_ex2_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1.issue    <= i_issue;
    r_ex1.op       <= i_dec_op;
    r_ex2          <= r_ex1;
    r_ex2_rs1_data <= i_rs1_data;
    r_ex3          <= r_ex2;
    r_ex3_old      <= i_csr_rd_data;
    r_ex3_new      <= w_ex2_new;
  end

  assign o_rs1_rnid = r_ex1.issue.rs1_rnid;

  // The instruction ahead of us is in ex3 now, so its result is on o_phy_wr
  assign w_fwd_ext = i_ext_wr.valid && (i_ext_wr.rd_rnid == r_ex2.issue.rs1_rnid) &&
                     (r_ex2.issue.rs1_rnid != '0);
  assign w_fwd_own = o_phy_wr.valid && (o_phy_wr.rd_rnid == r_ex2.issue.rs1_rnid) &&
                     (r_ex2.issue.rs1_rnid != '0);

  always_comb begin
    if (!r_ex2.issue.rs1_valid) begin
      w_ex2_rs1 = '0;
    end else if (w_fwd_ext) begin
      w_ex2_rs1 = i_ext_wr.rd_data;
    end else if (w_fwd_own) begin
      w_ex2_rs1 = o_phy_wr.rd_data;
    end else begin
      w_ex2_rs1 = r_ex2_rs1_data;
    end
  end

  assign o_csr_rd_addr = r_ex2.issue.inst[31:20];

  always_comb begin
    case (r_ex2.op)
      OP_RW:   w_ex2_new = w_ex2_rs1;
      OP_RS:   w_ex2_new = i_csr_rd_data | w_ex2_rs1;
      OP_RC:   w_ex2_new = i_csr_rd_data & ~w_ex2_rs1;
      default: w_ex2_new = i_csr_rd_data;
    endcase
  end

  assign o_csr_wr_valid = r_ex3_valid &&
                          ((r_ex3.op == OP_RW) || (r_ex3.op == OP_RS) || (r_ex3.op == OP_RC));
  assign o_csr_wr_addr  = r_ex3.issue.inst[31:20];
  assign o_csr_wr_data  = r_ex3_new;

  assign o_phy_wr.valid   = r_ex3_valid && r_ex3.issue.rd_valid && (r_ex3.issue.rd_rnid != '0);
  assign o_phy_wr.rd_rnid = r_ex3.issue.rd_rnid;
  assign o_phy_wr.rd_data = r_ex3_old;

  assign w_ex3_mret = r_ex3_valid && (r_ex3.op == OP_MRET);

  assign o_done.done       = r_ex3_valid;
  assign o_done.index_oh   = r_ex3.issue.index;
  assign o_done.excpt_vld  = w_ex3_mret;
  assign o_done.excpt_type = w_ex3_mret ? EXC_MRET : EXC_NONE;

  a_excpt_needs_done : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    o_done.excpt_vld |-> o_done.done
  ) else $error("csu_pipe: exception flagged without completion");

endmodule

//--- hdl/csu_pkg.sv
package csu_pkg;

  localparam int XLEN          = 32;
  localparam int RNID_W        = 5;
  localparam int PHYS_REGS     = 1 << RNID_W;
  localparam int RV_ENTRY_SIZE = 8;
  localparam int CSR_ADDR_W    = 12;

  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;

  localparam logic [6:0]  OPC_SYSTEM = 7'b1110011;
  localparam logic [2:0]  F3_CSRRW   = 3'd1;
  localparam logic [2:0]  F3_CSRRS   = 3'd2;
  localparam logic [2:0]  F3_CSRRC   = 3'd3;
  localparam logic [31:0] INST_MRET  = 32'h3020_0073;  // Full encoding, no operand fields

  typedef enum logic [2:0] {
    OP_NONE,
    OP_RW,
    OP_RS,
    OP_RC,
    OP_MRET
  } csu_op_e;

  typedef enum logic {
    EXC_NONE,
    EXC_MRET
  } excpt_e;

  typedef struct packed {
    logic                     valid;
    logic [31:0]              inst;
    logic                     rs1_valid;
    logic [RNID_W-1:0]        rs1_rnid;
    logic                     rd_valid;
    logic [RNID_W-1:0]        rd_rnid;
    logic [RV_ENTRY_SIZE-1:0] index;  // One-hot reservation-station slot
  } issue_t;

  typedef struct packed {
    logic              valid;
    logic [RNID_W-1:0] rd_rnid;
    logic [XLEN-1:0]   rd_data;
  } phy_wr_t;

  typedef struct packed {
    logic                     done;
    logic [RV_ENTRY_SIZE-1:0] index_oh;
    logic                     excpt_vld;
    excpt_e                   excpt_type;
  } done_t;

endpackage

//--- hdl/csu_top.sv
module csu_top (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  csu_pkg::issue_t  i_issue,
  input  csu_pkg::phy_wr_t i_ext_wr,
  output csu_pkg::phy_wr_t o_phy_wr,
  output csu_pkg::done_t   o_done
);

  import csu_pkg::*;

  logic [31:0]           w_dec_inst;
  csu_op_e               w_dec_op;
  logic [RNID_W-1:0]     w_rs1_rnid;
  logic [XLEN-1:0]       w_rs1_data;
  logic [CSR_ADDR_W-1:0] w_csr_rd_addr;
  logic [XLEN-1:0]       w_csr_rd_data;
  logic                  w_csr_wr_valid;
  logic [CSR_ADDR_W-1:0] w_csr_wr_addr;
  logic [XLEN-1:0]       w_csr_wr_data;

  csu_decoder u_decoder (
    .i_inst (w_dec_inst),
    .o_op   (w_dec_op)
  );

  csu_pipe u_pipe (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_issue        (i_issue),
    .o_dec_inst     (w_dec_inst),
    .i_dec_op       (w_dec_op),
    .o_rs1_rnid     (w_rs1_rnid),
    .i_rs1_data     (w_rs1_data),
    .i_ext_wr       (i_ext_wr),
    .o_csr_rd_addr  (w_csr_rd_addr),
    .i_csr_rd_data  (w_csr_rd_data),
    .o_csr_wr_valid (w_csr_wr_valid),
    .o_csr_wr_addr  (w_csr_wr_addr),
    .o_csr_wr_data  (w_csr_wr_data),
    .o_phy_wr       (o_phy_wr),
    .o_done         (o_done)
  );

  phys_regfile u_regfile (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_rd_rnid (w_rs1_rnid),
    .o_rd_data (w_rs1_data),
    .i_wr0     (o_phy_wr),  // Own results retire here
    .i_wr1     (i_ext_wr)
  );

  csr_file u_csr_file (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_rd_addr  (w_csr_rd_addr),
    .o_rd_data  (w_csr_rd_data),
    .i_wr_valid (w_csr_wr_valid),
    .i_wr_addr  (w_csr_wr_addr),
    .i_wr_data  (w_csr_wr_data)
  );

endmodule

//--- hdl/phys_regfile.sv
module phys_regfile (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic [csu_pkg::RNID_W-1:0] i_rd_rnid,
  output logic [csu_pkg::XLEN-1:0]   o_rd_data,
  input  csu_pkg::phy_wr_t           i_wr0,
  input  csu_pkg::phy_wr_t           i_wr1
);

  import csu_pkg::*;

  logic [XLEN-1:0] r_regs [PHYS_REGS];
  logic            w_wr0_en;
  logic            w_wr1_en;

  assign w_wr0_en = i_wr0.valid && (i_wr0.rd_rnid != '0);
  assign w_wr1_en = i_wr1.valid && (i_wr1.rd_rnid != '0);

  always_ff @(posedge i_clk) begin
    if (w_wr0_en) begin
      r_regs[i_wr0.rd_rnid] <= i_wr0.rd_data;
    end
    if (w_wr1_en) begin
      r_regs[i_wr1.rd_rnid] <= i_wr1.rd_data;
    end
  end

  // A result landing this cycle is seen by the reader immediately
  always_comb begin
    if (i_rd_rnid == '0) begin
      o_rd_data = '0;
    end else if (w_wr1_en && (i_wr1.rd_rnid == i_rd_rnid)) begin
      o_rd_data = i_wr1.rd_data;
    end else if (w_wr0_en && (i_wr0.rd_rnid == i_rd_rnid)) begin
      o_rd_data = i_wr0.rd_data;
    end else begin
      o_rd_data = r_regs[i_rd_rnid];
    end
  end

  // Rename hands out each physical id to a single producer, so the CSU and the
  // other pipes never retire into the same register together
  a_no_dual_write : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    !(w_wr0_en && w_wr1_en && (i_wr0.rd_rnid == i_wr1.rd_rnid))
  ) else $error("phys_regfile: both write ports target id %0d", i_wr0.rd_rnid);

endmodule

//--- sources.f
hdl/csu_pkg.sv
hdl/csu_decoder.sv
hdl/phys_regfile.sv
hdl/csr_file.sv
hdl/csu_pipe.sv
hdl/csu_top.sv
tb/csu_tb.sv

//--- tb/csu_tb.sv
module csu_tb;

  import csu_pkg::*;

  localparam int SLOT_W = $clog2(RV_ENTRY_SIZE);

  typedef struct packed {
    logic [RNID_W-1:0]     ext_rn;  // Zero leaves the external bus idle
    csu_op_e               op;      // OP_NONE leaves the issue port idle
    logic [CSR_ADDR_W-1:0] csr;
    logic [RNID_W-1:0]     rs1;
    logic [RNID_W-1:0]     rd;
    logic [SLOT_W-1:0]     slot;
  } row_t;

  logic            i_clk;
  logic            i_reset_n;
  issue_t          i_issue;
  phy_wr_t         i_ext_wr;
  phy_wr_t         o_phy_wr;
  done_t           o_done;
  row_t            tbl [$];
  string           tbl_name [$];
  int              exp_row [int];  // Table row due to complete at each step
  logic [XLEN-1:0] exp_data [int];
  logic [XLEN-1:0] m_reg [PHYS_REGS];
  logic [XLEN-1:0] m_csr [logic [CSR_ADDR_W-1:0]];
  logic [31:0]     lcg_state;
  int              cyc;
  int              outstanding;
  int              wait_cnt;

  csu_top dut0 (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_issue   (i_issue),
    .i_ext_wr  (i_ext_wr),
    .o_phy_wr  (o_phy_wr),
    .o_done    (o_done)
  );

  always #20 i_clk = ~i_clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [31:0] encode(input row_t r);
    logic [2:0] f3;
    if (r.op == OP_MRET) begin
      return 32'h3020_0073;
    end
    f3 = (r.op == OP_RS) ? 3'd2 : (r.op == OP_RC) ? 3'd3 : 3'd1;
    return {r.csr, r.rs1, f3, r.rd, 7'b1110011};
  endfunction

  // One instruction as the architecture sees it, applied at its ex2 step
  function automatic logic [XLEN-1:0] evaluate(input row_t r);
    logic [XLEN-1:0] src;
    logic [XLEN-1:0] old;
    src = m_reg[r.rs1];
    old = m_csr.exists(r.csr) ? m_csr[r.csr] : '0;
    if (r.op != OP_MRET && m_csr.exists(r.csr)) begin
      case (r.op)
        OP_RS:   m_csr[r.csr] = old | src;
        OP_RC:   m_csr[r.csr] = old & ~src;
        default: m_csr[r.csr] = src;
      endcase
    end
    if (r.rd != '0) begin
      m_reg[r.rd] = old;
    end
    return old;
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1, "mismatch at step %0d", cyc);
    end
  endtask

  task automatic add_row(input string name, input int ext_rn, input csu_op_e op,
                         input logic [CSR_ADDR_W-1:0] csr, input int rs1, input int rd);
    row_t r;
    r.ext_rn = RNID_W'(ext_rn);
    r.op     = op;
    r.csr    = csr;
    r.rs1    = RNID_W'(rs1);
    r.rd     = RNID_W'(rd);
    r.slot   = SLOT_W'(tbl.size() % RV_ENTRY_SIZE);
    tbl.push_back(r);
    tbl_name.push_back(name);
  endtask

  task automatic build_table();
    logic [CSR_ADDR_W-1:0] csrs [4];
    csrs = '{CSR_MSTATUS, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC};
    for (int i = 1; i <= 6; i++) begin
      add_row("preload", i, OP_NONE, '0, 0, 0);
    end
    for (int i = 0; i < 4; i++) begin
      add_row("csrrw first", 0, OP_RW, csrs[i], i + 1, i + 8);
    end
    for (int i = 0; i < 4; i++) begin
      add_row("csrrs readback", 0, OP_RS, csrs[i], 0, i + 12);
    end
    add_row("csrrs set bits", 0, OP_RS, CSR_MSTATUS, 5, 16);
    add_row("csrrc clear bits", 0, OP_RC, CSR_MSTATUS, 6, 17);
    add_row("set clear readback", 0, OP_RS, CSR_MSTATUS, 0, 18);
    add_row("rs1 regfile bypass", 0, OP_RW, CSR_MTVEC, 20, 19);
    add_row("ext write in ex1", 20, OP_NONE, '0, 0, 0);
    add_row("rs1 ext forward", 0, OP_RW, CSR_MEPC, 21, 22);
    add_row("gap", 0, OP_NONE, '0, 0, 0);
    add_row("ext write in ex2", 21, OP_NONE, '0, 0, 0);
    add_row("producer", 0, OP_RS, CSR_MSCRATCH, 0, 23);
    add_row("rs1 one issue back", 0, OP_RW, CSR_MEPC, 23, 24);
    add_row("rs1 two issues back", 0, OP_RW, CSR_MTVEC, 23, 25);
    add_row("mepc readback", 0, OP_RS, CSR_MEPC, 0, 26);
    add_row("mtvec readback", 0, OP_RS, CSR_MTVEC, 0, 27);
    add_row("mret", 0, OP_MRET, 12'h302, 0, 0);  // Address field of the MRET encoding
    add_row("mepc after mret", 0, OP_RS, CSR_MEPC, 0, 28);
    add_row("unknown csr write", 0, OP_RW, 12'h7c0, 1, 29);
    add_row("unknown csr read", 0, OP_RS, 12'h7c0, 0, 30);
    add_row("rd x0", 0, OP_RW, CSR_MSTATUS, 2, 0);
    add_row("rd x0 readback", 0, OP_RS, CSR_MSTATUS, 0, 31);
  endtask

  task automatic check_outputs();
    row_t  r;
    string n;
    if (!exp_row.exists(cyc)) begin
      compare("idle cycle done", 32'd0, 32'(o_done.done));
    end else begin
      r = tbl[exp_row[cyc]];
      n = tbl_name[exp_row[cyc]];
      compare({n, " done"}, 32'd1, 32'(o_done.done));
      compare({n, " index"}, 32'(RV_ENTRY_SIZE'(1) << r.slot), 32'(o_done.index_oh));
      compare({n, " excpt_vld"}, 32'(r.op == OP_MRET), 32'(o_done.excpt_vld));
      compare({n, " excpt_type"}, 32'((r.op == OP_MRET) ? EXC_MRET : EXC_NONE),
              32'(o_done.excpt_type));
      compare({n, " rd valid"}, 32'(r.rd != '0), 32'(o_phy_wr.valid));
      if (r.rd != '0) begin
        compare({n, " rd id"}, 32'(r.rd), 32'(o_phy_wr.rd_rnid));
        compare({n, " rd data"}, exp_data[cyc], o_phy_wr.rd_data);
      end
      outstanding--;
    end
  endtask

  task automatic step(input int idx);
    row_t r;
    r = '0;
    if (idx >= 0) begin
      r = tbl[idx];
    end
    @(negedge i_clk);
    check_outputs();
    i_ext_wr = '0;
    i_issue  = '0;
    if (r.ext_rn != '0) begin
      i_ext_wr.valid   = 1'b1;
      i_ext_wr.rd_rnid = r.ext_rn;
      i_ext_wr.rd_data = lcg_next();
      m_reg[r.ext_rn]  = i_ext_wr.rd_data;
    end
    if (r.op != OP_NONE) begin
      i_issue.valid     = 1'b1;
      i_issue.inst      = encode(r);
      i_issue.rs1_valid = 1'b1;
      i_issue.rs1_rnid  = r.rs1;
      i_issue.rd_valid  = 1'b1;
      i_issue.rd_rnid   = r.rd;
      i_issue.index     = RV_ENTRY_SIZE'(1) << r.slot;
      exp_row[cyc + 3]  = idx;
      outstanding++;
    end
    if (exp_row.exists(cyc + 1)) begin  // That row is in ex2 during this cycle
      exp_data[cyc + 1] = evaluate(tbl[exp_row[cyc + 1]]);
    end
    cyc++;
  endtask

  initial begin
    i_clk       = 1'b0;
    i_reset_n   = 1'b0;
    i_issue     = '0;
    i_ext_wr    = '0;
    lcg_state   = 32'd26;
    cyc         = 0;
    outstanding = 0;
    m_reg       = '{default: '0};
    m_csr[CSR_MSTATUS]  = '0;
    m_csr[CSR_MTVEC]    = '0;
    m_csr[CSR_MSCRATCH] = '0;
    m_csr[CSR_MEPC]     = '0;
    build_table();
    repeat (10) @(negedge i_clk);
    i_reset_n = 1'b1;
    foreach (tbl[i]) begin
      step(i);
    end
    wait_cnt = 0;
    while (outstanding > 0 && wait_cnt < 10) begin
      step(-1);
      wait_cnt++;
    end
    if (outstanding == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("Timeout while waiting for %0d completions", outstanding);
      $display("FAIL: see errors above");
      $fatal(1, "completion timeout");
    end
  end

endmodule
